// File: compile.f
joystickPkg.sv
spiByteIf.sv
jstkSampleIf.sv
pollTimer.sv
spiByteShifter.sv
spiFrameCtrl.sv
axisRepeater.sv
joystickTop.sv
jstkSlaveModel.sv
joystickTop_tb.sv

// File: Makefile
# Verilator build and run for the joystick reader

VERILATOR ?= verilator
TOP       ?= joystickTop_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: joystickTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module joystickTop_tb;

    localparam int TIMEOUT_CYCLES = 20 * joystickPkg::HOLD_DELAY;
    localparam int SCLK_EDGES     = joystickPkg::SPI_BITS * joystickPkg::FRAME_BYTES;

    logic CLK;
    logic RST;
    logic MISO;
    logic SS;
    logic SCLK;
    logic MOSI;
    logic left;
    logic right;
    logic up;
    logic down;
    logic click;
    logic downClick;

    joystickPkg::axisPos_t stickX;          // Driven into the model
    joystickPkg::axisPos_t stickY;
    joystickPkg::buttons_t stickButtons;
    joystickPkg::axisPos_t servedX;         // What the model sent this frame
    joystickPkg::axisPos_t servedY;
    joystickPkg::buttons_t servedButtons;
    joystickPkg::axisPos_t heldX;           // Last complete frame, as seen here
    joystickPkg::axisPos_t heldY;

    logic [3:0] dirs;                       // left, right, up, down at 0..3
    logic [3:0] beyond;                     // Held position past that direction's threshold
    logic       ssLast;
    logic       sclkLast;
    int         sclkRises;                  // SCLK rises in the current frame
    int         pulseTotal[4];
    int         pulseNum[4];                // Pulses since the axis left the band
    int         gap[4];                     // Cycles since the last pulse
    int         expMin[4];
    int         expMax[4];
    int         cycleCount = 0;
    logic       checkNow;                   // One-cycle checkpoint for the totals
    string      testName;
    string      dirName[4] = '{"left", "right", "up", "down"};

    assign dirs   = {down, up, right, left};
    assign beyond = {heldY > joystickPkg::HIGH_THRESH, heldY < joystickPkg::LOW_THRESH,
                     heldX > joystickPkg::HIGH_THRESH, heldX < joystickPkg::LOW_THRESH};

    joystickTop UUT (
        .CLK       (CLK),
        .RST       (RST),
        .MISO      (MISO),
        .SS        (SS),
        .SCLK      (SCLK),
        .MOSI      (MOSI),
        .left      (left),
        .right     (right),
        .up        (up),
        .down      (down),
        .click     (click),
        .downClick (downClick)
    );

    jstkSlaveModel stick (
        .SS            (SS),
        .SCLK          (SCLK),
        .MISO          (MISO),
        .xPos          (stickX),
        .yPos          (stickY),
        .buttons       (stickButtons),
        .servedX       (servedX),
        .servedY       (servedY),
        .servedButtons (servedButtons)
    );

    // ====================
    // Error handling
    // ====================
    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic reportMismatch(input string test, input string expected, input string actual);
        stopOnError($sformatf("MISMATCH %s expected %s actual %s", test, expected, actual));
    endtask

    // ====================
    // Clock and watchdog
    // ====================
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES)
            stopOnError("Timeout, the run did not finish within the cycle limit");
    end

    // Observed activity, values read before this edge's updates
    always @(posedge CLK) begin
        if (RST) begin
            heldX     <= joystickPkg::CENTRE_POS;
            heldY     <= joystickPkg::CENTRE_POS;
            ssLast    <= 1'b1;
            sclkLast  <= 1'b0;
            sclkRises <= 0;
            for (int d = 0; d < 4; d++) begin
                pulseTotal[d] <= 0;
                pulseNum[d]   <= 0;
                gap[d]        <= 0;
            end
        end else begin
            ssLast   <= SS;
            sclkLast <= SCLK;
            if (SS && !ssLast) begin        // Frame just finished
                heldX <= servedX;
                heldY <= servedY;
            end
            if (SS)
                sclkRises <= 0;
            else if (SCLK && !sclkLast)
                sclkRises <= sclkRises + 1;
            for (int d = 0; d < 4; d++) begin
                if (dirs[d]) begin
                    pulseTotal[d] <= pulseTotal[d] + 1;
                    pulseNum[d]   <= pulseNum[d] + 1;
                    gap[d]        <= 1;
                end else begin
                    gap[d] <= gap[d] + 1;
                    if (!beyond[d])
                        pulseNum[d] <= 0;   // Back in band, next pulse is a leave pulse
                end
            end
        end
    end

    // ====================
    // Assertions
    // ====================
    resetState: assert property (@(posedge CLK)
        $fell(RST) |-> SS && !SCLK && (dirs == 4'b0000))
        else stopOnError("Outputs were not idle right after reset");

    sclkParked: assert property (@(posedge CLK) disable iff (RST)
        SS |-> !SCLK)
        else stopOnError("SCLK was high while SS was high");

    mosiLow: assert property (@(posedge CLK) disable iff (RST)
        !MOSI)
        else stopOnError("MOSI left its low level");

    edgesPerFrame: assert property (@(posedge CLK) disable iff (RST)
        $rose(SS) |-> sclkRises == SCLK_EDGES)
        else reportMismatch("sclk rises per frame", $sformatf("%0d", SCLK_EDGES),
                            $sformatf("%0d", $sampled(sclkRises)));

    buttonsFollowFrame: assert property (@(posedge CLK) disable iff (RST)
        $rose(SS) |-> {downClick, click} == servedButtons)
        else reportMismatch("buttons", $sformatf("%b", $sampled(servedButtons)),
                            $sformatf("%b", $sampled({downClick, click})));

    xExclusive: assert property (@(posedge CLK) disable iff (RST)
        !(left && right))
        else stopOnError("left and right were high together");

    yExclusive: assert property (@(posedge CLK) disable iff (RST)
        !(up && down))
        else stopOnError("up and down were high together");

    for (genvar d = 0; d < 4; d++) begin : dirChecks
        singleCycle: assert property (@(posedge CLK) disable iff (RST)
            dirs[d] |=> !dirs[d])
            else stopOnError($sformatf("Pulse on %s lasted more than one cycle", dirName[d]));

        // No pulse unless the served stick is past this direction's threshold
        onlyWhenBeyond: assert property (@(posedge CLK) disable iff (RST)
            dirs[d] |-> beyond[d])
            else stopOnError($sformatf("Pulse on %s with the stick not pushed that way",
                                       dirName[d]));

        firstRepeat: assert property (@(posedge CLK) disable iff (RST)
            dirs[d] && (pulseNum[d] == 1) |-> gap[d] >= joystickPkg::HOLD_DELAY)
            else reportMismatch($sformatf("first repeat gap %s", dirName[d]),
                                $sformatf(">= %0d", joystickPkg::HOLD_DELAY),
                                $sformatf("%0d", $sampled(gap[d])));

        laterRepeat: assert property (@(posedge CLK) disable iff (RST)
            dirs[d] && (pulseNum[d] >= 2) |-> gap[d] == joystickPkg::REPEAT_PERIOD)
            else reportMismatch($sformatf("repeat period %s", dirName[d]),
                                $sformatf("%0d", joystickPkg::REPEAT_PERIOD),
                                $sformatf("%0d", $sampled(gap[d])));

        totalsInRange: assert property (@(posedge CLK) disable iff (RST)
            checkNow |-> (pulseTotal[d] >= expMin[d]) && (pulseTotal[d] <= expMax[d]))
            else reportMismatch($sformatf("%s pulses on %s", testName, dirName[d]),
                                $sformatf("%0d..%0d", expMin[d], expMax[d]),
                                $sformatf("%0d", $sampled(pulseTotal[d])));
    end

    // ====================
    // Stimulus helpers
    // ====================
    function automatic joystickPkg::axisPos_t lowPos();
        return joystickPkg::axisPos_t'($urandom_range(int'(joystickPkg::LOW_THRESH) - 1, 0));
    endfunction

    function automatic joystickPkg::axisPos_t highPos();
        return joystickPkg::axisPos_t'($urandom_range(1023, int'(joystickPkg::HIGH_THRESH) + 1));
    endfunction

    // Anywhere in the centre band, edges included
    function automatic joystickPkg::axisPos_t bandPos();
        return joystickPkg::axisPos_t'($urandom_range(int'(joystickPkg::HIGH_THRESH),
                                                      int'(joystickPkg::LOW_THRESH)));
    endfunction

    task automatic waitFrameEnd();
        @(posedge SS);
        @(posedge CLK);
        #1;
    endtask

    // New stick values, then wait until a frame has carried them
    task automatic setStick(input joystickPkg::axisPos_t x, input joystickPkg::axisPos_t y);
        stickX       = x;
        stickY       = y;
        stickButtons = joystickPkg::buttons_t'($urandom_range(3, 0));
        waitFrameEnd();
    endtask

    // d picks the direction, frames extends the push
    task automatic pushDirection(input int d, input int frames);
        joystickPkg::axisPos_t off;
        off = (d % 2 == 0) ? lowPos() : highPos();
        if (d < 2)
            setStick(off, bandPos());
        else
            setStick(bandPos(), off);
        repeat (frames) waitFrameEnd();
        setStick(bandPos(), bandPos());
    endtask

    task automatic checkTotals(input string name);
        testName = name;
        checkNow = 1'b1;
        @(posedge CLK);
        #1;
        checkNow = 1'b0;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        void'($urandom(32'hea9a));
        RST          = 1'b1;
        checkNow     = 1'b0;
        testName     = "reset";
        stickX       = joystickPkg::CENTRE_POS;
        stickY       = joystickPkg::CENTRE_POS;
        stickButtons = '0;
        for (int d = 0; d < 4; d++) begin
            expMin[d] = 0;
            expMax[d] = 0;
        end
        repeat (10) @(posedge CLK);
        #1;
        RST = 1'b0;

        // Centred stick, buttons only
        setStick(bandPos(), bandPos());
        setStick(bandPos(), bandPos());
        checkTotals("centred");

        // One brief push per direction, shorter than the hold delay
        for (int d = 0; d < 4; d++) begin
            pushDirection(d, 0);
            expMin[d] = expMin[d] + 1;
            expMax[d] = expMax[d] + 1;
            checkTotals($sformatf("short push %s", dirName[d]));
        end

        // Long holds right and up, repeats then silence after release
        for (int d = 1; d < 3; d++) begin
            expMin[d] = pulseTotal[d] + 3;  // Leave pulse plus at least two repeats
            expMax[d] = pulseTotal[d] + 10;
            pushDirection(d, 6);
            repeat (2) waitFrameEnd();
            checkTotals($sformatf("hold %s", dirName[d]));
            expMin[d] = pulseTotal[d];
            expMax[d] = pulseTotal[d];
        end

        repeat (2) waitFrameEnd();
        checkTotals("released");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: jstkSlaveModel.sv
`timescale 1ns/1ps
`default_nettype none

// PmodJSTK stand-in for the testbench
// Latches the stick at SS fall, shifts the frame out MSB first on SCLK falls
module jstkSlaveModel (
    input  wire                        SS,
    input  wire                        SCLK,
    output wire                        MISO,
    input  wire joystickPkg::axisPos_t xPos,           // Stick set by testbench
    input  wire joystickPkg::axisPos_t yPos,
    input  wire joystickPkg::buttons_t buttons,
    output wire joystickPkg::axisPos_t servedX,        // Values in the current frame
    output wire joystickPkg::axisPos_t servedY,
    output wire joystickPkg::buttons_t servedButtons
);

    localparam int FRAME_BITS = joystickPkg::SPI_BITS * joystickPkg::FRAME_BYTES;

    joystickPkg::axisPos_t xLatched   = joystickPkg::CENTRE_POS;
    joystickPkg::axisPos_t yLatched   = joystickPkg::CENTRE_POS;
    joystickPkg::buttons_t btnLatched = '0;
    logic [FRAME_BITS-1:0] frameWord;   // Whole frame, byte 0 on top
    logic [FRAME_BITS-1:0] frameShift;  // Frame moved up by the falls so far
    int                    fallCnt = 0; // SCLK falls since SS fell

    // ====================
    // Frame layout
    // ====================
    // y low, y high, x low, x high, buttons
    assign frameWord = {yLatched[7:0], 6'b0, yLatched[9:8],
                        xLatched[7:0], 6'b0, xLatched[9:8],
                        6'b0, btnLatched};

    assign frameShift = frameWord << fallCnt;
    assign MISO       = frameShift[FRAME_BITS-1];  // MSB valid before first rise

    assign servedX       = xLatched;
    assign servedY       = yLatched;
    assign servedButtons = btnLatched;

    // Frame loaded as the master selects us
    always @(negedge SS) begin
        xLatched   <= xPos;
        yLatched   <= yPos;
        btnLatched <= buttons;
    end

    // Mode 0, next bit goes out on the falling edge
    always @(negedge SCLK or posedge SS) begin
        if (SS)
            fallCnt <= 0;               // Deselected, rewind
        else
            fallCnt <= fallCnt + 1;
    end

endmodule

`default_nettype wire

// File: joystickTop.sv
`timescale 1ns/1ps
`default_nettype none

// PmodJSTK reader with repeating direction outputs
module joystickTop (
    input  wire CLK,
    input  wire RST,
    input  wire MISO,
    output wire SS,
    output wire SCLK,
    output wire MOSI,
    output wire left,
    output wire right,
    output wire up,
    output wire down,
    output wire click,
    output wire downClick
);

    logic sclkTick;
    logic pollStrobe;

    spiByteIf    spiBus ();     // Frame FSM to shifter
    jstkSampleIf sampleBus ();  // Decoded sample

    assign MOSI      = 1'b0;                  // No command byte sent
    assign click     = sampleBus.buttons[0];
    assign downClick = sampleBus.buttons[1];

    // ====================
    // SPI path
    // ====================
    pollTimer timer (
        .CLK        (CLK),
        .RST        (RST),
        .sclkTick   (sclkTick),
        .pollStrobe (pollStrobe)
    );

    spiByteShifter shifter (
        .CLK      (CLK),
        .RST      (RST),
        .sclkTick (sclkTick),
        .MISO     (MISO),
        .SCLK     (SCLK),
        .spi      (spiBus.shifter)
    );

    spiFrameCtrl frameCtrl (
        .CLK        (CLK),
        .RST        (RST),
        .pollStrobe (pollStrobe),
        .SS         (SS),
        .spi        (spiBus.ctrl),
        .sample     (sampleBus.source)
    );

    // ====================
    // Direction outputs
    // ====================
    axisRepeater xRepeater (
        .CLK        (CLK),
        .RST        (RST),
        .pos        (sampleBus.xPos),
        .minusPulse (left),
        .plusPulse  (right)
    );

    axisRepeater yRepeater (
        .CLK        (CLK),
        .RST        (RST),
        .pos        (sampleBus.yPos),
        .minusPulse (up),     // Low y is up
        .plusPulse  (down)
    );

endmodule

`default_nettype wire

// File: axisRepeater.sv
`timescale 1ns/1ps
`default_nettype none

// One axis to direction pulses, with hold delay then auto-repeat
module axisRepeater (
    input  wire                   CLK,
    input  wire                   RST,
    input  wire joystickPkg::axisPos_t pos,  // Held sample position
    output logic                  minusPulse, // Below LOW_THRESH
    output logic                  plusPulse   // Above HIGH_THRESH
);

    joystickPkg::axisState_t         state;
    joystickPkg::axisState_t         nextState;
    logic [joystickPkg::COUNT_W-1:0] count;
    logic [joystickPkg::COUNT_W-1:0] nextCount;
    logic                            nextMinus;
    logic                            nextPlus;
    logic                            isLow;
    logic                            isHigh;
    logic                            lowSide;   // FSM tracking the low side
    logic                            stillOut;  // Still past the same threshold

    assign isLow    = (pos < joystickPkg::LOW_THRESH);
    assign isHigh   = (pos > joystickPkg::HIGH_THRESH);
    assign lowSide  = (state == joystickPkg::HOLD_LOW) || (state == joystickPkg::REPEAT_LOW);
    assign stillOut = lowSide ? isLow : isHigh;

    // ====================
    // Next-state logic
    // ====================
    always_comb begin
        nextState = state;
        nextCount = '0;     // Counter clears unless a branch counts
        nextMinus = 1'b0;
        nextPlus  = 1'b0;
        case (state)
            joystickPkg::IDLE: begin
                if (isHigh) begin
                    nextState = joystickPkg::HOLD_HIGH;
                    nextPlus  = 1'b1;                   // Leave-centre pulse
                end else if (isLow) begin
                    nextState = joystickPkg::HOLD_LOW;
                    nextMinus = 1'b1;
                end
            end
            joystickPkg::HOLD_LOW, joystickPkg::HOLD_HIGH: begin
                if (!stillOut)
                    nextState = joystickPkg::IDLE;      // Back in band, silent
                else if (count == joystickPkg::HOLD_LAST)
                    nextState = lowSide ? joystickPkg::REPEAT_LOW : joystickPkg::REPEAT_HIGH;
                else
                    nextCount = count + 1'b1;
            end
            joystickPkg::REPEAT_LOW, joystickPkg::REPEAT_HIGH: begin
                if (!stillOut) begin
                    nextState = joystickPkg::IDLE;
                end else if (count == joystickPkg::REPEAT_LAST) begin
                    nextMinus = lowSide;                // Periodic repeat
                    nextPlus  = !lowSide;
                end else begin
                    nextCount = count + 1'b1;
                end
            end
            default: nextState = joystickPkg::IDLE;
        endcase
    end

    // Registered pulses, one cycle each
    always_ff @(posedge CLK) begin
        if (RST) begin
            state      <= joystickPkg::IDLE;
            count      <= '0;
            minusPulse <= 1'b0;
            plusPulse  <= 1'b0;
        end else begin
            state      <= nextState;
            count      <= nextCount;
            minusPulse <= nextMinus;
            plusPulse  <= nextPlus;
        end
    end

    // Opposite directions are exclusive
    noDualPulse: assert property (@(posedge CLK) disable iff (RST)
        !(minusPulse && plusPulse))
        else $error("axisRepeater minus and plus together");

endmodule

`default_nettype wire

// File: spiFrameCtrl.sv
`timescale 1ns/1ps
`default_nettype none

// Five-byte joystick read under SS, decoded into one sample
module spiFrameCtrl (
    input  wire          CLK,
    input  wire          RST,
    input  wire          pollStrobe,  // Frame request
    output logic         SS,          // Slave select, active low
    spiByteIf.ctrl       spi,
    jstkSampleIf.source  sample
);

    typedef enum logic [1:0] {
        FRM_IDLE,   // SS high, waiting for poll
        FRM_START,  // Byte request on the bus
        FRM_WAIT,   // Shifter running
        FRM_DONE    // Sample just updated
    } frameState_t;

    frameState_t                        state;
    frameState_t                        nextState;
    logic [joystickPkg::BYTE_CNT_W-1:0] byteCnt;   // Index of byte in flight
    logic                               byteDone;  // Shifter finished a byte
    logic                               lastByte;  // Byte in flight is the 5th

    // Bytes 0..3, byte 0 ends up in the top slot
    joystickPkg::spiByte_t [joystickPkg::FRAME_BYTES-2:0] frameSr;

    assign byteDone = (state == FRM_WAIT) && spi.done;
    assign lastByte = (byteCnt == joystickPkg::BYTE_LAST);

    assign spi.start          = (state == FRM_START);  // Single cycle per byte
    assign sample.sampleValid = (state == FRM_DONE);

    // ====================
    // Frame FSM
    // ====================
    always_comb begin
        nextState = state;
        case (state)
            FRM_IDLE:  if (pollStrobe) nextState = FRM_START;  // Poll ignored elsewhere
            FRM_START: nextState = FRM_WAIT;
            FRM_WAIT: begin
                if (byteDone)
                    nextState = lastByte ? FRM_DONE : FRM_START;
            end
            FRM_DONE:  nextState = FRM_IDLE;
            default:   nextState = FRM_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= FRM_IDLE;
            SS      <= 1'b1;
            byteCnt <= '0;
        end else begin
            state <= nextState;
            if ((state == FRM_IDLE) && pollStrobe) begin
                SS      <= 1'b0;   // Select falls with first start
                byteCnt <= '0;
            end else if (byteDone) begin
                if (lastByte)
                    SS <= 1'b1;    // Release after 5th byte
                else
                    byteCnt <= byteCnt + 1'b1;
            end
        end
    end

    // Frame assembly
    always_ff @(posedge CLK) begin
        if (byteDone)
            frameSr <= {frameSr[joystickPkg::FRAME_BYTES-3:0], spi.rxByte};
    end

    // ====================
    // Sample decode
    // ====================
    // Byte 4 is still on rxByte when the 5th done arrives
    always_ff @(posedge CLK) begin
        if (RST) begin
            sample.xPos    <= joystickPkg::CENTRE_POS;
            sample.yPos    <= joystickPkg::CENTRE_POS;
            sample.buttons <= '0;
        end else if (byteDone && lastByte) begin
            sample.yPos    <= {frameSr[2][1:0], frameSr[3]};  // Bytes 1, 0
            sample.xPos    <= {frameSr[0][1:0], frameSr[1]};  // Bytes 3, 2
            sample.buttons <= spi.rxByte[1:0];
        end
    end

    // Shifter never runs with the slave deselected
    busyUnderSs: assert property (@(posedge CLK) disable iff (RST)
        spi.busy |-> !SS)
        else $error("spiFrameCtrl byte transfer with SS high");

endmodule

`default_nettype wire

// File: spiByteShifter.sv
`timescale 1ns/1ps
`default_nettype none

// SPI mode 0 receiver, one byte per start
// SCLK idles low, MISO taken on each rising edge, MSB first
module spiByteShifter (
    input  wire        CLK,
    input  wire        RST,
    input  wire        sclkTick,  // Half-period pacing
    input  wire        MISO,
    output logic       SCLK,
    spiByteIf.shifter  spi
);

    logic [joystickPkg::BIT_CNT_W-1:0] riseCnt;   // Rising edges so far
    joystickPkg::spiByte_t             rxSr;      // Receive shift register
    logic                              riseEdge;  // SCLK goes high this cycle
    logic                              fallEdge;  // SCLK goes low this cycle
    logic                              lastFall;  // Fall after 8th rise

    assign riseEdge = spi.busy && sclkTick && !SCLK;
    assign fallEdge = spi.busy && sclkTick && SCLK;
    assign lastFall = fallEdge && (riseCnt == joystickPkg::BIT_LAST);

    assign spi.rxByte = rxSr;  // Stable from last rise until next start

    // ====================
    // Control and SCLK
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            spi.busy <= 1'b0;
            spi.done <= 1'b0;
            SCLK     <= 1'b0;
            riseCnt  <= '0;
        end else begin
            spi.done <= lastFall;  // Pulse lines up with busy dropping
            if (spi.start && !spi.busy) begin
                spi.busy <= 1'b1;
                riseCnt  <= '0;
            end else if (riseEdge) begin
                SCLK    <= 1'b1;
                riseCnt <= riseCnt + 1'b1;
            end else if (fallEdge) begin
                SCLK <= 1'b0;
                if (lastFall)
                    spi.busy <= 1'b0;  // Byte complete
            end
        end
    end

    // Data path, sampled with the rising edge
    always_ff @(posedge CLK) begin
        if (riseEdge)
            rxSr <= {rxSr[joystickPkg::SPI_BITS-2:0], MISO};
    end

    // ====================
    // Checks
    // ====================
    // Frame FSM must wait for the previous byte
    startWhileBusy: assert property (@(posedge CLK) disable iff (RST)
        spi.start |-> !spi.busy)
        else $error("spiByteShifter start while busy");

    // SCLK parked low outside a byte
    sclkIdleLow: assert property (@(posedge CLK) disable iff (RST)
        !spi.busy |-> !SCLK)
        else $error("spiByteShifter SCLK high while idle");

endmodule

`default_nettype wire

// File: pollTimer.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running pacing for SCLK and the frame poll
module pollTimer (
    input  wire  CLK,
    input  wire  RST,
    output logic sclkTick,   // Every SCLK_HALF cycles
    output logic pollStrobe  // Every POLL_PERIOD cycles
);

    logic [joystickPkg::SCLK_CNT_W-1:0] sclkCnt;
    logic [joystickPkg::POLL_CNT_W-1:0] pollCnt;
    logic                               sclkWrap;
    logic                               pollWrap;

    assign sclkWrap = (sclkCnt == joystickPkg::SCLK_LAST);
    assign pollWrap = (pollCnt == joystickPkg::POLL_LAST);

    // ====================
    // Serial clock pacing
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            sclkCnt  <= '0;
            sclkTick <= 1'b0;
        end else begin
            sclkTick <= sclkWrap;          // Registered strobe
            if (sclkWrap)
                sclkCnt <= '0;
            else
                sclkCnt <= sclkCnt + 1'b1;
        end
    end

    // ====================
    // Poll interval
    // ====================
    always_ff @(posedge CLK) begin
        if (RST) begin
            pollCnt    <= '0;
            pollStrobe <= 1'b0;
        end else begin
            pollStrobe <= pollWrap;        // One frame request per period
            if (pollWrap)
                pollCnt <= '0;
            else
                pollCnt <= pollCnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: jstkSampleIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded joystick sample, held between frames
interface jstkSampleIf;
    joystickPkg::axisPos_t xPos;        // Left/right position
    joystickPkg::axisPos_t yPos;        // Up/down position
    joystickPkg::buttons_t buttons;     // Click bits
    logic                  sampleValid; // One cycle after new values land

    modport source (output xPos, output yPos, output buttons, output sampleValid);
    modport sink   (input  xPos, input  yPos, input  buttons, input  sampleValid);
endinterface

`default_nettype wire

// File: spiByteIf.sv
`timescale 1ns/1ps
`default_nettype none

// Byte request/response between frame FSM and SPI shifter
interface spiByteIf;
    logic                  start;   // One-cycle request, only while !busy
    logic                  busy;    // Shifter active
    logic                  done;    // One-cycle end of byte
    joystickPkg::spiByte_t rxByte;  // Valid with done, held after

    modport ctrl    (output start, input  busy, input  done, input  rxByte);
    modport shifter (input  start, output busy, output done, output rxByte);
endinterface

`default_nettype wire

// File: joystickPkg.sv
`default_nettype none

package joystickPkg;

    // ====================
    // Data widths
    // ====================
    typedef logic [9:0] axisPos_t;     // One axis reading
    typedef logic [7:0] spiByte_t;     // One byte on MISO
    typedef logic [1:0] buttons_t;     // Bit 0 click, bit 1 downClick

    localparam int SPI_BITS    = 8;    // Bits per byte
    localparam int FRAME_BYTES = 5;    // Bytes per joystick frame

    // Axis decision levels
    localparam axisPos_t HIGH_THRESH = 10'd750;
    localparam axisPos_t LOW_THRESH  = 10'd300;
    localparam axisPos_t CENTRE_POS  = 10'd512;  // Stick at rest

    // ====================
    // Timing in CLK cycles
    // ====================
    // Simulation values, a board build uses 30M / 10M / 20M / 750
    localparam int HOLD_DELAY    = 3000;
    localparam int REPEAT_PERIOD = 1000;
    localparam int POLL_PERIOD   = 1000;
    localparam int SCLK_HALF     = 4;

    // Counter widths
    localparam int COUNT_W    = $clog2(HOLD_DELAY + 1);
    localparam int POLL_CNT_W = $clog2(POLL_PERIOD + 1);
    localparam int SCLK_CNT_W = $clog2(SCLK_HALF + 1);
    localparam int BIT_CNT_W  = $clog2(SPI_BITS + 1);
    localparam int BYTE_CNT_W = $clog2(FRAME_BYTES);

    // Terminal counts, sized to their counters
    localparam logic [COUNT_W-1:0]    HOLD_LAST   = COUNT_W'(HOLD_DELAY - 1);
    localparam logic [COUNT_W-1:0]    REPEAT_LAST = COUNT_W'(REPEAT_PERIOD - 1);
    localparam logic [POLL_CNT_W-1:0] POLL_LAST   = POLL_CNT_W'(POLL_PERIOD - 1);
    localparam logic [SCLK_CNT_W-1:0] SCLK_LAST   = SCLK_CNT_W'(SCLK_HALF - 1);
    localparam logic [BIT_CNT_W-1:0]  BIT_LAST    = BIT_CNT_W'(SPI_BITS);
    localparam logic [BYTE_CNT_W-1:0] BYTE_LAST   = BYTE_CNT_W'(FRAME_BYTES - 1);

    // Per-axis direction FSM
    typedef enum logic [2:0] {
        IDLE,           // Inside centre band
        HOLD_LOW,       // Below band, waiting out hold delay
        HOLD_HIGH,      // Above band, waiting out hold delay
        REPEAT_LOW,     // Below band, pulsing each period
        REPEAT_HIGH     // Above band, pulsing each period
    } axisState_t;

endpackage

`default_nettype wire
